//--- hw/neoBusPkg.sv
`default_nettype none

package neoBusPkg;

  // register bus geometry
  localparam int addrWidth = 18;
  localparam int dataWidth = 8;

  // the two top address bits select the region
  localparam logic [1:0] regionVirtual = 2'd0;
  localparam logic [1:0] regionDelta   = 2'd1;
  localparam logic [1:0] regionRaw     = 2'd2;
  localparam logic [1:0] regionReg     = 2'd3;

  // register index in the low four address bits
  localparam logic [3:0] regMaxLo  = 4'd0;
  localparam logic [3:0] regMaxHi  = 4'd1;
  localparam logic [3:0] regCtrl   = 4'd2;
  localparam logic [3:0] regStatus = 4'd3;

  // bit positions inside the control register
  localparam int ctrlInitBit  = 0;
  localparam int ctrlLimitBit = 1;
  localparam int ctrlRunBit   = 2;
  localparam int ctrlLoopBit  = 3;
  localparam int ctrl32Bit    = 4;

endpackage

`default_nettype wire

//--- hw/neoPixelPkg.sv
`default_nettype none

package neoPixelPkg;

  // raw pixel byte buffer
  localparam int bufferEnd  = 255;
  localparam int bufferBits = 8;

  // delta (remap) table
  localparam int virtualEnd  = 63;
  localparam int virtualBits = 6;

  localparam int maxBits = 13; // width of the max register

  // a delta word is either a plain raw byte index, or a pixel slot whose
  // two low bits get replaced by the channel when running in 32-bit mode
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [13:0] slot;
      logic [1:0]  lowBits;
    } pixel;
  } deltaEntry;

  // line timing in bus clock cycles, kept short for simulation
  localparam int bitPeriod = 8;
  localparam int highZero  = 2;
  localparam int highOne   = 5;
  localparam int resetGap  = 40;

  // credits each receiver hands out at reset
  localparam int fifoDepth    = 4;
  localparam int encoderSlots = 1;

endpackage

`default_nettype wire

//--- hw/pixelStreamIf.sv
`timescale 1ns/1ps
`default_nettype none

// byte link where the sender only transmits against credits it holds
interface pixelStreamIf;
  logic       valid;
  logic [7:0] data;
  logic       last;   // final byte of a frame
  logic       credit; // one-cycle pulse when the receiver frees a slot

  modport sender (
    output valid, data, last,
    input  credit
  );

  modport receiver (
    input  valid, data, last,
    output credit
  );
endinterface

`default_nettype wire

//--- hw/pixelRam.sv
`timescale 1ns/1ps
`default_nettype none

module pixelRam #(
  parameter int dataBits  = 8,
  parameter int depthBits = 8
) (
  input  wire                 busClk,
  input  wire [depthBits-1:0] rdAddr,
  output logic [dataBits-1:0] rdData,
  input  wire                 wrEn,
  input  wire [depthBits-1:0] wrAddr,
  input  wire [dataBits-1:0]  wrData
);

  logic [dataBits-1:0] mem [2**depthBits];

  // a read in the same cycle as a write to that address returns the old word
  always_ff @(posedge busClk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
    rdData <= mem[rdAddr]; // one cycle read latency
  end

endmodule

`default_nettype wire

//--- hw/neoRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module neoRegisters (
  input  wire                                busClk,
  input  wire                                arstN,
  input  wire [neoBusPkg::addrWidth-1:0]     busAddr,
  input  wire [neoBusPkg::dataWidth-1:0]     busDataIn,
  input  wire                                busWrite,
  input  wire                                busRead,
  output logic [neoBusPkg::dataWidth-1:0]    busDataOut,
  output logic                               busReady,
  input  wire [neoPixelPkg::bufferBits-1:0]  pixelIx,
  output logic [7:0]                         pixelByte,
  input  wire                                frameDone,
  input  wire                                busy,
  output logic [neoPixelPkg::maxBits-1:0]    regMax,
  output logic                               regLimit,
  output logic                               regRun
);

  logic [1:0] region;
  logic [3:0] regIx;
  logic       virtualPending; // second stage of a virtual write
  logic [1:0] virtualChan;
  logic [7:0] deltaLow;
  logic [15:0] deltaWord;
  neoPixelPkg::deltaEntry entry;
  logic [neoPixelPkg::virtualBits-1:0] deltaRdAddr;
  logic [neoPixelPkg::bufferBits-1:0]  pixelWrAddr;
  logic [neoPixelPkg::bufferBits-1:0]  mappedIx;
  logic pixelWrEn;
  logic deltaWrEn;
  logic ctrlInit;
  logic ctrlLimit;
  logic ctrlRun;
  logic ctrlLoop;
  logic ctrl32;
  logic [neoBusPkg::dataWidth-1:0] ctrlWord;

  assign region = busAddr[neoBusPkg::addrWidth-1 -: 2];
  assign regIx  = busAddr[3:0];

  // the delta lookup starts in the busWrite cycle so the word is ready one cycle later
  assign deltaRdAddr = ctrl32 ? busAddr[neoPixelPkg::virtualBits+1:2]
                              : busAddr[neoPixelPkg::virtualBits-1:0];

  assign entry    = deltaWord;
  assign mappedIx = ctrl32 ? {entry.pixel.slot[neoPixelPkg::bufferBits-3:0], virtualChan}
                           : entry.raw[neoPixelPkg::bufferBits-1:0];

  // busDataIn is still held by the master during the second virtual stage
  assign pixelWrEn   = virtualPending || (busWrite && region == neoBusPkg::regionRaw);
  assign pixelWrAddr = virtualPending ? mappedIx : busAddr[neoPixelPkg::bufferBits-1:0];

  assign deltaWrEn = busWrite && region == neoBusPkg::regionDelta && busAddr[0]; // odd commits

  assign busReady = ~virtualPending;
  assign regLimit = ctrlLimit;
  assign regRun   = ctrlRun & ~frameDone; // dips for one cycle so the fetcher sees frame ends

  always_comb begin
    ctrlWord = '0;
    ctrlWord[neoBusPkg::ctrlInitBit]  = ctrlInit;
    ctrlWord[neoBusPkg::ctrlLimitBit] = ctrlLimit;
    ctrlWord[neoBusPkg::ctrlRunBit]   = ctrlRun;
    ctrlWord[neoBusPkg::ctrlLoopBit]  = ctrlLoop;
    ctrlWord[neoBusPkg::ctrl32Bit]    = ctrl32;
  end

  pixelRam #(.dataBits(8), .depthBits(neoPixelPkg::bufferBits)) pixelBuf (
    .busClk (busClk),
    .rdAddr (pixelIx),
    .rdData (pixelByte),
    .wrEn   (pixelWrEn),
    .wrAddr (pixelWrAddr),
    .wrData (busDataIn)
  );

  pixelRam #(.dataBits(16), .depthBits($clog2(neoPixelPkg::virtualEnd + 1))) deltaBuf (
    .busClk (busClk),
    .rdAddr (deltaRdAddr),
    .rdData (deltaWord),
    .wrEn   (deltaWrEn),
    .wrAddr (busAddr[neoPixelPkg::virtualBits:1]),
    .wrData ({busDataIn, deltaLow})
  );

  always_ff @(posedge busClk or negedge arstN) begin
    if (!arstN) begin
      virtualPending <= 1'b0;
      regMax         <= '0;
      ctrlInit       <= 1'b0;
      ctrlLimit      <= 1'b0;
      ctrlRun        <= 1'b0;
      ctrlLoop       <= 1'b0;
      ctrl32         <= 1'b0;
    end else begin
      virtualPending <= busWrite && region == neoBusPkg::regionVirtual;

      if (frameDone) ctrlRun <= ctrlLoop; // keep running only in loop mode

      if (ctrlInit) begin
        ctrlInit  <= 1'b0;
        ctrlLimit <= 1'b0;
        ctrlRun   <= 1'b0;
        ctrlLoop  <= 1'b0;
        ctrl32    <= 1'b0;
      end

      if (busWrite && region == neoBusPkg::regionReg) begin
        case (regIx)
          neoBusPkg::regMaxLo: regMax[7:0] <= busDataIn;
          neoBusPkg::regMaxHi: regMax[neoPixelPkg::maxBits-1:8] <=
                                 busDataIn[neoPixelPkg::maxBits-9:0];
          neoBusPkg::regCtrl: begin
            ctrlInit  <= busDataIn[neoBusPkg::ctrlInitBit];
            ctrlLimit <= busDataIn[neoBusPkg::ctrlLimitBit];
            ctrlRun   <= busDataIn[neoBusPkg::ctrlRunBit];
            ctrlLoop  <= busDataIn[neoBusPkg::ctrlLoopBit];
            ctrl32    <= busDataIn[neoBusPkg::ctrl32Bit];
          end
          default: ; // status is read only
        endcase
      end
    end
  end

  always_ff @(posedge busClk) begin
    if (busWrite && region == neoBusPkg::regionVirtual) begin
      virtualChan <= busAddr[1:0];
    end
    if (busWrite && region == neoBusPkg::regionDelta && !busAddr[0]) begin
      deltaLow <= busDataIn; // low half waits for the odd write
    end

    if (busRead) begin
      if (region == neoBusPkg::regionReg) begin
        case (regIx)
          neoBusPkg::regMaxLo:  busDataOut <= regMax[7:0];
          neoBusPkg::regMaxHi:  busDataOut <= {3'b000, regMax[neoPixelPkg::maxBits-1:8]};
          neoBusPkg::regCtrl:   busDataOut <= ctrlWord;
          neoBusPkg::regStatus: busDataOut <= {{(neoBusPkg::dataWidth-1){1'b0}}, busy};
          default:              busDataOut <= '0;
        endcase
      end else begin
        busDataOut <= '1; // buffers are write only from the bus
      end
    end
  end

  // a virtual write stalls the master for exactly one cycle
  assert property (@(posedge busClk) disable iff (!arstN) !busReady |=> busReady)
    else $error("busReady low for more than one cycle");

  assert property (@(posedge busClk) disable iff (!arstN) !busReady |-> !busWrite)
    else $error("bus write issued while busReady is low");

endmodule

`default_nettype wire

//--- hw/pixelFetcher.sv
`timescale 1ns/1ps
`default_nettype none

module pixelFetcher (
  input  wire                               busClk,
  input  wire                               arstN,
  input  wire                               regRun,
  input  wire                               regLimit,
  input  wire [neoPixelPkg::maxBits-1:0]    regMax,
  output logic [neoPixelPkg::bufferBits-1:0] pixelIx,
  input  wire [7:0]                         pixelByte,
  output logic                              busy,
  pixelStreamIf.sender                      link
);

  typedef enum logic [1:0] {sIdle, sFetch, sWait} fetchState;

  fetchState state;
  logic [neoPixelPkg::bufferBits-1:0] ix;
  logic [2:0] credits;   // holds 0 up to the FIFO depth
  logic readPending;     // RAM word arrives this cycle
  logic lastPending;
  logic atLast;
  logic issue;

  // a limit beyond the buffer still stops at the buffer end
  assign atLast = (ix == neoPixelPkg::bufferBits'(neoPixelPkg::bufferEnd)) ||
                  (regLimit && neoPixelPkg::maxBits'(ix) == regMax);

  // one read per credit, and never a second one while a read is in flight
  assign issue = state == sFetch && regRun && credits != 3'd0 && !readPending;

  assign pixelIx    = ix;
  assign busy       = state != sIdle;
  assign link.valid = readPending;
  assign link.data  = pixelByte;
  assign link.last  = lastPending;

  always_ff @(posedge busClk or negedge arstN) begin
    if (!arstN) begin
      state       <= sIdle;
      ix          <= '0;
      credits     <= 3'(neoPixelPkg::fifoDepth);
      readPending <= 1'b0;
      lastPending <= 1'b0;
    end else begin
      readPending <= issue;
      if (issue) lastPending <= atLast;
      credits <= credits - {2'b00, issue} + {2'b00, link.credit};

      case (state)
        sIdle: begin
          if (regRun) begin
            state <= sFetch;
            ix    <= '0;
          end
        end
        sFetch: begin
          if (!regRun) begin
            state <= sIdle; // run cleared in the middle of a frame
          end else if (issue) begin
            if (atLast) state <= sWait;
            else ix <= ix + 1'b1;
          end
        end
        default: begin
          if (!regRun) state <= sIdle; // frame finished on the line
        end
      endcase
    end
  end

  assert property (@(posedge busClk) disable iff (!arstN)
                   credits <= 3'(neoPixelPkg::fifoDepth))
    else $error("fetcher holds more credits than the FIFO has slots");

endmodule

`default_nettype wire

//--- hw/pixelFifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixelFifo (
  input  wire             busClk,
  input  wire             arstN,
  pixelStreamIf.receiver  inLink,
  pixelStreamIf.sender    outLink
);

  logic [8:0] queue [neoPixelPkg::fifoDepth]; // {last, data}
  logic [1:0] wrPtr;
  logic [1:0] rdPtr;
  logic [2:0] count;
  logic [1:0] downCredits;
  logic deq;

  assign deq = count != 3'd0 && downCredits != 2'd0;

  always_ff @(posedge busClk) begin
    if (inLink.valid) begin
      queue[wrPtr] <= {inLink.last, inLink.data}; // credits guarantee a free slot
    end
    if (deq) begin
      {outLink.last, outLink.data} <= queue[rdPtr];
    end
  end

  always_ff @(posedge busClk or negedge arstN) begin
    if (!arstN) begin
      wrPtr          <= '0;
      rdPtr          <= '0;
      count          <= '0;
      downCredits    <= 2'(neoPixelPkg::encoderSlots);
      outLink.valid  <= 1'b0;
      inLink.credit  <= 1'b0;
    end else begin
      if (inLink.valid) wrPtr <= wrPtr + 1'b1;
      if (deq) rdPtr <= rdPtr + 1'b1;
      count         <= count + {2'b00, inLink.valid} - {2'b00, deq};
      downCredits   <= downCredits - {1'b0, deq} + {1'b0, outLink.credit};
      outLink.valid <= deq;
      inLink.credit <= deq; // slot freed, hand its credit back upstream
    end
  end

  assert property (@(posedge busClk) disable iff (!arstN)
                   inLink.valid |-> count != 3'(neoPixelPkg::fifoDepth))
    else $error("byte arrived at a full FIFO");

endmodule

`default_nettype wire

//--- hw/neoEncoder.sv
`timescale 1ns/1ps
`default_nettype none

module neoEncoder (
  input  wire             busClk,
  input  wire             arstN,
  pixelStreamIf.receiver  link,
  output logic            neoData,
  output logic            frameDone
);

  typedef enum logic [1:0] {sIdle, sBits, sGap} encState;

  encState state;
  logic       slotFull;  // the single receive slot
  logic [7:0] slotData;
  logic       slotLast;
  logic [7:0] shifter;
  logic       curLast;
  logic [2:0] phase;     // cycle inside the bit period
  logic [2:0] bitIx;
  logic [5:0] gapCnt;
  logic       periodEnd;
  logic       byteEnd;
  logic       load;

  assign periodEnd = state == sBits && phase == 3'(neoPixelPkg::bitPeriod - 1);
  assign byteEnd   = periodEnd && bitIx == 3'd7;

  // a waiting byte follows the previous one without a gap on the line
  assign load = slotFull && (state == sIdle || (byteEnd && !curLast));

  assign neoData = state == sBits &&
                   phase < (shifter[7] ? 3'(neoPixelPkg::highOne) : 3'(neoPixelPkg::highZero));

  always_ff @(posedge busClk) begin
    if (link.valid) begin
      slotData <= link.data;
      slotLast <= link.last;
    end
    if (load) begin
      shifter <= slotData;
      curLast <= slotLast;
    end else if (periodEnd) begin
      shifter <= {shifter[6:0], 1'b0}; // MSB goes out first
    end
  end

  always_ff @(posedge busClk or negedge arstN) begin
    if (!arstN) begin
      state       <= sIdle;
      slotFull    <= 1'b0;
      phase       <= '0;
      bitIx       <= '0;
      gapCnt      <= '0;
      link.credit <= 1'b0;
      frameDone   <= 1'b0;
    end else begin
      link.credit <= load; // the slot is free again once its byte moves to the shifter
      frameDone   <= 1'b0;

      if (load) slotFull <= 1'b0;
      else if (link.valid) slotFull <= 1'b1;

      if (load) begin
        state <= sBits;
        phase <= '0;
        bitIx <= '0;
      end else begin
        case (state)
          sBits: begin
            if (periodEnd) begin
              phase <= '0;
              bitIx <= bitIx + 1'b1;
              if (bitIx == 3'd7) begin
                state  <= curLast ? sGap : sIdle;
                gapCnt <= '0;
              end
            end else begin
              phase <= phase + 1'b1;
            end
          end
          sGap: begin
            // line stays low so the strip latches the frame
            if (gapCnt == 6'(neoPixelPkg::resetGap - 1)) begin
              state     <= sIdle;
              frameDone <= 1'b1;
            end else begin
              gapCnt <= gapCnt + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/neoPixelTop.sv
`timescale 1ns/1ps
`default_nettype none

module neoPixelTop (
  input  wire                             busClk,
  input  wire                             arstN,
  input  wire [neoBusPkg::addrWidth-1:0]  busAddr,
  input  wire [neoBusPkg::dataWidth-1:0]  busDataIn,
  input  wire                             busWrite,
  input  wire                             busRead,
  output wire [neoBusPkg::dataWidth-1:0]  busDataOut,
  output wire                             busReady,
  output wire                             neoData
);

  logic [neoPixelPkg::bufferBits-1:0] pixelIx;
  logic [7:0]                         pixelByte;
  logic [neoPixelPkg::maxBits-1:0]    regMax;
  logic regLimit;
  logic regRun;
  logic frameDone;
  logic busy;

  pixelStreamIf fetchLink ();  // fetcher to FIFO, four credits
  pixelStreamIf encodeLink (); // FIFO to encoder, one credit

  neoRegisters i_registers (
    .busClk     (busClk),
    .arstN      (arstN),
    .busAddr    (busAddr),
    .busDataIn  (busDataIn),
    .busWrite   (busWrite),
    .busRead    (busRead),
    .busDataOut (busDataOut),
    .busReady   (busReady),
    .pixelIx    (pixelIx),
    .pixelByte  (pixelByte),
    .frameDone  (frameDone),
    .busy       (busy),
    .regMax     (regMax),
    .regLimit   (regLimit),
    .regRun     (regRun)
  );

  pixelFetcher i_fetcher (
    .busClk    (busClk),
    .arstN     (arstN),
    .regRun    (regRun),
    .regLimit  (regLimit),
    .regMax    (regMax),
    .pixelIx   (pixelIx),
    .pixelByte (pixelByte),
    .busy      (busy),
    .link      (fetchLink.sender)
  );

  pixelFifo i_fifo (
    .busClk  (busClk),
    .arstN   (arstN),
    .inLink  (fetchLink.receiver),
    .outLink (encodeLink.sender)
  );

  neoEncoder i_encoder (
    .busClk    (busClk),
    .arstN     (arstN),
    .link      (encodeLink.receiver),
    .neoData   (neoData),
    .frameDone (frameDone)
  );

endmodule

`default_nettype wire

//--- tb/neoPixelTb.sv
`timescale 1ns/1ps
`default_nettype none

module neoPixelTb;

  typedef logic [7:0] byteQueue [$];

  localparam int halfPeriod = 4;
  localparam int frameTotal = 6; // frames that reach the line over the whole run
  localparam int byteTotal  = 10 + 32 + 32 + 3 * 6;
  localparam int cycleLimit = byteTotal * 8 * neoPixelPkg::bitPeriod +
                              frameTotal * (neoPixelPkg::resetGap + 100) + 6000;
  localparam int gapDetect  = 3 * neoPixelPkg::bitPeriod; // no pause between bytes gets this long

  localparam logic [7:0] initMask  = 8'(1 << neoBusPkg::ctrlInitBit);
  localparam logic [7:0] limitMask = 8'(1 << neoBusPkg::ctrlLimitBit);
  localparam logic [7:0] runMask   = 8'(1 << neoBusPkg::ctrlRunBit);
  localparam logic [7:0] loopMask  = 8'(1 << neoBusPkg::ctrlLoopBit);
  localparam logic [7:0] wideMask  = 8'(1 << neoBusPkg::ctrl32Bit);

  logic                            busClk    = 1'b0;
  logic                            arstN     = 1'b0;
  logic [neoBusPkg::addrWidth-1:0] busAddr   = '0;
  logic [neoBusPkg::dataWidth-1:0] busDataIn = '0;
  logic                            busWrite  = 1'b0;
  logic                            busRead   = 1'b0;
  wire  [neoBusPkg::dataWidth-1:0] busDataOut;
  wire                             busReady;
  wire                             neoData;

  logic [7:0]  shadowBuf [256];
  logic [15:0] shadowDelta [64];
  logic [31:0] lfsrState;
  logic        mode32;     // mirrors the 32-bit bit for the shadow remap
  byteQueue    expQ;
  byteQueue    lineQ;      // bytes rebuilt from the data line
  string       testName;
  int          cycles     = 0;
  int          frameCount = 0;
  int          byteCount  = 0;
  int          highCnt;
  int          lowCnt;
  int          bitCnt;
  logic        inFrame;
  logic [7:0]  shiftByte;
  logic [7:0]  readValue;
  int          startFrames;
  int          startBytes;

  neoPixelTop i_dut (
    .busClk     (busClk),
    .arstN      (arstN),
    .busAddr    (busAddr),
    .busDataIn  (busDataIn),
    .busWrite   (busWrite),
    .busRead    (busRead),
    .busDataOut (busDataOut),
    .busReady   (busReady),
    .neoData    (neoData)
  );

  always #halfPeriod busClk = ~busClk;

  task automatic abortRun(input string why);
    $display("Result: FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic checkByte(input logic [7:0] expected, input logic [7:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: pixel byte expected %02h, actual %02h", testName, expected, actual);
      abortRun("a pixel byte on the data line differs from the reference");
    end
  endtask

  task automatic checkReg(input logic [neoBusPkg::dataWidth-1:0] expected,
                          input logic [neoBusPkg::dataWidth-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: register expected %02h, actual %02h", testName, expected, actual);
      abortRun("a register read returned the wrong value");
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] randomBits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      r = {r[14:0], lfsrState[0]};
    end
    return r;
  endfunction

  // the frame runs from index 0 to regMax under limit, else to the buffer end
  function automatic byteQueue expectedFrame(input logic limit, input logic [12:0] maxIx);
    byteQueue frame;
    int lastIx;
    lastIx = (limit && maxIx < 13'd255) ? int'(maxIx) : 255;
    for (int i = 0; i <= lastIx; i++) begin
      frame.push_back(shadowBuf[i]);
    end
    return frame;
  endfunction

  task automatic queueFrame(input logic limit, input logic [12:0] maxIx);
    byteQueue frame;
    frame = expectedFrame(limit, maxIx);
    foreach (frame[i]) expQ.push_back(frame[i]);
  endtask

  task automatic writeBus(input logic [1:0] region, input logic [15:0] offset,
                          input logic [7:0] data);
    @(posedge busClk);
    while (!busReady) @(posedge busClk);
    busAddr   <= {region, offset};
    busDataIn <= data; // held until the next access for the virtual second stage
    busWrite  <= 1'b1;
    @(posedge busClk);
    busWrite <= 1'b0;
  endtask

  task automatic readBus(input logic [1:0] region, input logic [15:0] offset,
                         output logic [7:0] value);
    @(posedge busClk);
    while (!busReady) @(posedge busClk);
    busAddr <= {region, offset};
    busRead <= 1'b1;
    @(posedge busClk);
    busRead <= 1'b0;
    @(posedge busClk);
    value = busDataOut;
  endtask

  task automatic writeCtrl(input logic [7:0] value);
    writeBus(neoBusPkg::regionReg, 16'(neoBusPkg::regCtrl), value);
  endtask

  task automatic setMax(input logic [12:0] m);
    writeBus(neoBusPkg::regionReg, 16'(neoBusPkg::regMaxLo), m[7:0]);
    writeBus(neoBusPkg::regionReg, 16'(neoBusPkg::regMaxHi), {3'b000, m[12:8]});
  endtask

  task automatic writeRaw(input logic [7:0] ix, input logic [7:0] data);
    writeBus(neoBusPkg::regionRaw, {8'h00, ix}, data);
    shadowBuf[ix] = data;
  endtask

  // low byte at the even address, the odd address commits the word
  task automatic writeDelta(input logic [5:0] v, input logic [15:0] value);
    writeBus(neoBusPkg::regionDelta, {9'd0, v, 1'b0}, value[7:0]);
    writeBus(neoBusPkg::regionDelta, {9'd0, v, 1'b1}, value[15:8]);
    shadowDelta[v] = value;
  endtask

  task automatic writeVirtual(input logic [7:0] a, input logic [7:0] data);
    logic [15:0] entry;
    logic [7:0]  rawIx;
    entry = mode32 ? shadowDelta[a[7:2]] : shadowDelta[a[5:0]];
    rawIx = mode32 ? {entry[7:2], a[1:0]} : entry[7:0]; // channel takes the two low bits
    writeBus(neoBusPkg::regionVirtual, {8'h00, a}, data);
    shadowBuf[rawIx] = data;
  endtask

  task automatic waitIdle();
    logic [7:0] status;
    status = 8'h01;
    while (status[0]) readBus(neoBusPkg::regionReg, 16'(neoBusPkg::regStatus), status);
  endtask

  task automatic finishFrames(input int target);
    while (frameCount < target) @(posedge busClk);
    waitIdle();
    if (expQ.size() != 0) abortRun("the frame ended before all expected bytes appeared");
  endtask

  // measures each high pulse on the line and rebuilds bytes MSB first
  always @(posedge busClk) begin
    if (!arstN) begin
      highCnt = 0;
      lowCnt = 0;
      bitCnt = 0;
      inFrame = 1'b0;
      shiftByte = '0;
      frameCount <= 0;
      byteCount <= 0;
    end else if (neoData && lowCnt >= gapDetect && lowCnt < neoPixelPkg::resetGap) begin
      abortRun("the reset gap on the data line is shorter than required");
    end else if (neoData) begin
      highCnt = highCnt + 1;
      lowCnt = 0;
    end else if (highCnt != 0 && highCnt != neoPixelPkg::highOne &&
                 highCnt != neoPixelPkg::highZero) begin
      abortRun($sformatf("a high pulse of %0d cycles is neither a 0 nor a 1", highCnt));
    end else if (lowCnt + 1 == gapDetect && inFrame && bitCnt != 0) begin
      abortRun("the data line went idle in the middle of a byte");
    end else begin
      lowCnt = lowCnt + 1;
      if (highCnt != 0) begin
        shiftByte = {shiftByte[6:0], highCnt == neoPixelPkg::highOne};
        highCnt = 0;
        bitCnt = bitCnt + 1;
        inFrame = 1'b1;
        if (bitCnt == 8) begin
          lineQ.push_back(shiftByte);
          byteCount <= byteCount + 1;
          bitCnt = 0;
        end
      end
      if (lowCnt == gapDetect && inFrame) begin
        frameCount <= frameCount + 1; // only a reset gap stays low this long
        inFrame = 1'b0;
      end
    end
  end

  always @(posedge busClk) begin
    if (arstN && lineQ.size() != 0) begin
      if (expQ.size() == 0) abortRun("a byte appeared on the data line with no frame expected");
      else checkByte(expQ.pop_front(), lineQ.pop_front());
    end
  end

  always @(posedge busClk) begin
    if (cycles >= cycleLimit) abortRun($sformatf("the run timed out after %0d cycles", cycles));
    else cycles <= cycles + 1;
  end

  initial begin
    lfsrState = 32'h7f3d;
    mode32 = 1'b0;
    testName = "reset";
    repeat (5) @(posedge busClk);
    arstN <= 1'b1;
    @(posedge busClk);
    if (!busReady || neoData) abortRun("busReady is low or the data line is high after reset");

    testName = "register readback";
    setMax(13'h1fa5);
    readBus(neoBusPkg::regionReg, 16'(neoBusPkg::regMaxLo), readValue);
    checkReg(8'ha5, readValue);
    readBus(neoBusPkg::regionReg, 16'(neoBusPkg::regMaxHi), readValue);
    checkReg(8'h1f, readValue);
    writeCtrl(limitMask | loopMask | wideMask);
    readBus(neoBusPkg::regionReg, 16'(neoBusPkg::regCtrl), readValue);
    checkReg(limitMask | loopMask | wideMask, readValue);
    readBus(neoBusPkg::regionReg, 16'(neoBusPkg::regStatus), readValue);
    checkReg(8'h00, readValue);
    readBus(neoBusPkg::regionRaw, 16'h0005, readValue);
    checkReg(8'hff, readValue);
    readBus(neoBusPkg::regionDelta, 16'h0003, readValue);
    checkReg(8'hff, readValue);
    writeCtrl(8'h00);

    testName = "raw frame with limit";
    for (int i = 0; i < 256; i++) writeRaw(8'(i), 8'(randomBits(8)));
    setMax(13'd9);
    queueFrame(1'b1, 13'd9);
    startFrames = frameCount;
    writeCtrl(limitMask | runMask);
    finishFrames(startFrames + 1);
    readBus(neoBusPkg::regionReg, 16'(neoBusPkg::regCtrl), readValue);
    checkReg(limitMask, readValue);

    testName = "virtual writes 8-bit";
    for (int v = 0; v < 16; v++) writeDelta(6'(v), {8'(randomBits(8)), 8'((v * 5 + 3) % 32)});
    for (int v = 0; v < 16; v++) writeVirtual(8'(v), 8'(randomBits(8)));
    setMax(13'd31);
    queueFrame(1'b1, 13'd31);
    startFrames = frameCount;
    writeCtrl(limitMask | runMask);
    finishFrames(startFrames + 1);

    testName = "virtual writes 32-bit";
    mode32 = 1'b1;
    writeCtrl(wideMask | limitMask);
    for (int v = 0; v < 8; v++) begin
      writeDelta(6'(v), {8'(randomBits(8)), 6'((v * 3 + 1) % 8), 2'(randomBits(2))});
    end
    for (int a = 0; a < 32; a++) writeVirtual(8'(a), 8'(randomBits(8)));
    queueFrame(1'b1, 13'd31);
    startFrames = frameCount;
    writeCtrl(wideMask | limitMask | runMask);
    finishFrames(startFrames + 1);
    readBus(neoBusPkg::regionReg, 16'(neoBusPkg::regCtrl), readValue);
    checkReg(wideMask | limitMask, readValue);

    testName = "loop mode";
    mode32 = 1'b0;
    setMax(13'd5);
    repeat (3) queueFrame(1'b1, 13'd5);
    startFrames = frameCount;
    startBytes = byteCount;
    writeCtrl(limitMask | runMask | loopMask);
    while (byteCount <= startBytes + 12) @(posedge busClk); // third frame is on the line
    writeCtrl(limitMask | runMask);
    finishFrames(startFrames + 3);
    readBus(neoBusPkg::regionReg, 16'(neoBusPkg::regCtrl), readValue);
    checkReg(limitMask, readValue);

    testName = "init";
    writeCtrl(limitMask | loopMask | wideMask);
    startFrames = frameCount;
    startBytes = byteCount;
    writeCtrl(initMask | limitMask | runMask | loopMask | wideMask);
    readBus(neoBusPkg::regionReg, 16'(neoBusPkg::regCtrl), readValue);
    checkReg(8'h00, readValue);
    repeat (200) @(posedge busClk);
    if (frameCount != startFrames || byteCount != startBytes) begin
      abortRun("bytes were streamed after the init write");
    end

    if (expQ.size() != 0 || lineQ.size() != 0) begin
      abortRun("bytes are left over at the end of the run");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- compile.f
hw/neoBusPkg.sv
hw/neoPixelPkg.sv
hw/pixelStreamIf.sv
hw/pixelRam.sv
hw/neoRegisters.sv
hw/pixelFetcher.sv
hw/pixelFifo.sv
hw/neoEncoder.sv
hw/neoPixelTop.sv
tb/neoPixelTb.sv

//--- Makefile
# Verilator build and run of the NeoPixel controller testbench

VERILATOR ?= verilator
TOP       ?= neoPixelTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# the simulation exits with a failing status when the testbench stops on $$fatal
test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
